//--- puc_rs5.f
+incdir+source
source/rv_isa_pkg.sv
source/rv_pipe_pkg.sv
source/regbank_if.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/retire.sv
source/regbank.sv
source/puc_rs5.sv
sim/puc_rs5_chk.sv
sim/tb_puc_rs5.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_puc_rs5 \
		-f puc_rs5.f -Mdir obj_dir -o tb_puc_rs5
	-./obj_dir/tb_puc_rs5 > sim.log 2>&1
	cat sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_puc_rs5.sv
`timescale 1ns/1ps
`default_nettype none

module tb_puc_rs5;

    import rv_isa_pkg::*;

    localparam int PROG_LEN = 51;               // Words in the program.
    localparam int ROWS     = 18;               // Stores expected on the right path.
    localparam int WATCHDOG_CYCLES = PROG_LEN * 20 + 200;

    // Expected stores, in program order.
    localparam word_t EXP_ADDR [ROWS] = '{
        32'h100, 32'h104, 32'h108, 32'h10c, 32'h110, 32'h114, 32'h118, 32'h11c, 32'h120,
        32'h124, 32'h128, 32'h12c, 32'h130, 32'h134, 32'h138, 32'h13c, 32'h140, 32'h144
    };
    localparam word_t EXP_DATA [ROWS] = '{
        32'h0000_0002, 32'h0000_0008, 32'h0000_0005, 32'hffff_fffd, 32'hffff_fff8,
        32'h0000_0001, 32'h0000_0000, 32'h0000_0028, 32'hffff_fffe, 32'h0000_000f,
        32'h1234_5000, 32'h0000_105c, 32'hc0de_0201, 32'h0000_0000, 32'h0000_0005,
        32'h0000_0094, 32'h0000_00a8, 32'hffff_fffd
    };

    logic       clk;
    logic       rst_i;
    logic       stall_i;
    word_t      instruction_i;
    word_t      mem_data_i;
    word_t      instruction_address_o;
    logic       mem_operation_enable_o;
    logic [3:0] mem_write_enable_o;
    word_t      mem_address_o;
    word_t      mem_data_o;

    word_t      rom [64];
    word_t      ram [256];
    int         prog_idx;
    word_t      store_addr_q [$];
    word_t      store_data_q [$];
    logic [3:0] store_strb_q [$];

    puc_rs5 i_puc_rs5 (
        .clk                    (clk),
        .rst_i                  (rst_i),
        .stall_i                (stall_i),
        .instruction_i          (instruction_i),
        .mem_data_i             (mem_data_i),
        .instruction_address_o  (instruction_address_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o)
    );

    // RV32I instruction formats.
    function automatic word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t i_type(input word_t imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input word_t imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type(input word_t imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                     input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic word_t j_type(input word_t imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(input word_t w);
        rom[prog_idx] = w;
        prog_idx++;
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_now($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_strobe(input string name, input logic [3:0] got,
                                input logic [3:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("error %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic load_program;
        prog_idx = 0;
        emit(i_type(5, 0, 3'b000, 1, OPC_OP_IMM));          // x1 = 5.
        emit(i_type(-3, 0, 3'b000, 2, OPC_OP_IMM));         // x2 = -3.
        emit(r_type(7'h00, 2, 1, 3'b000, 3));               // add, back to back.
        emit(s_type(32'h100, 3, 0));
        emit(r_type(7'h20, 2, 1, 3'b000, 4));               // sub.
        emit(s_type(32'h104, 4, 0));
        emit(r_type(7'h00, 2, 1, 3'b111, 5));               // and.
        emit(r_type(7'h00, 2, 1, 3'b110, 6));               // or.
        emit(r_type(7'h00, 2, 1, 3'b100, 7));               // xor.
        emit(s_type(32'h108, 5, 0));
        emit(s_type(32'h10c, 6, 0));
        emit(s_type(32'h110, 7, 0));
        emit(r_type(7'h00, 1, 2, 3'b010, 8));               // slt.
        emit(r_type(7'h00, 1, 2, 3'b011, 9));               // sltu.
        emit(s_type(32'h114, 8, 0));
        emit(s_type(32'h118, 9, 0));
        emit(i_type(3, 1, 3'b001, 10, OPC_OP_IMM));         // slli.
        emit(i_type(32'h401, 2, 3'b101, 11, OPC_OP_IMM));   // srai.
        emit(i_type(28, 2, 3'b101, 12, OPC_OP_IMM));        // srli.
        emit(s_type(32'h11c, 10, 0));
        emit(s_type(32'h120, 11, 0));
        emit(s_type(32'h124, 12, 0));
        emit(u_type(20'h12345, 13, OPC_LUI));
        emit(u_type(20'h00001, 14, OPC_AUIPC));             // At 0x5c.
        emit(i_type(32'h200, 0, 3'b010, 15, OPC_LOAD));     // lw. A store just before would own the bus.
        emit(i_type(1, 15, 3'b000, 16, OPC_OP_IMM));        // Load then use.
        emit(s_type(32'h128, 13, 0));
        emit(s_type(32'h12c, 14, 0));
        emit(s_type(32'h130, 16, 0));
        emit(i_type(7, 0, 3'b000, 0, OPC_OP_IMM));          // Write to x0.
        emit(s_type(32'h134, 0, 0));
        emit(b_type(8, 2, 1, 3'b000));                      // beq, not taken.
        emit(s_type(32'h138, 1, 0));
        emit(b_type(12, 2, 1, 3'b001));                     // bne, taken to 0x90.
        emit(s_type(32'h3f0, 1, 0));
        emit(s_type(32'h3f4, 1, 0));
        emit(j_type(12, 17));                               // jal to 0x9c.
        emit(s_type(32'h3f8, 1, 0));
        emit(s_type(32'h3fc, 1, 0));
        emit(s_type(32'h13c, 17, 0));
        emit(i_type(32'hb4, 0, 3'b000, 18, OPC_OP_IMM));
        emit(i_type(0, 18, 3'b000, 19, OPC_JALR));          // jalr to 0xb4.
        emit(s_type(32'h3f0, 1, 0));
        emit(s_type(32'h3f4, 1, 0));
        emit(s_type(32'h3f8, 1, 0));
        emit(s_type(32'h140, 19, 0));
        emit(b_type(8, 1, 2, 3'b100));                      // blt, taken.
        emit(s_type(32'h3fc, 1, 0));
        emit(b_type(8, 1, 2, 3'b101));                      // bge, not taken.
        emit(s_type(32'h144, 2, 0));
        emit(j_type(0, 0));                                 // Park here.
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memories. Sample mid cycle, answer after the next edge.
    always begin : memory_model
        word_t fetch_addr;
        word_t data_addr;
        logic  data_read;
        @(negedge clk);
        fetch_addr = instruction_address_o;
        data_addr  = mem_address_o;
        data_read  = mem_operation_enable_o && !stall_i;   // Held access gets no new answer.
        if (mem_write_enable_o != 4'b0000) begin
            store_addr_q.push_back(mem_address_o);
            store_data_q.push_back(mem_data_o);
            store_strb_q.push_back(mem_write_enable_o);
            ram[mem_address_o[9:2]] = mem_data_o;
        end
        @(posedge clk);
        #10;
        instruction_i = rom[fetch_addr[7:2]];
        if (data_read) begin
            mem_data_i = ram[data_addr[9:2]];
        end
        stall_i       = rst_i ? 1'b0 : ($urandom % 6 == 0);    // Random back-pressure.
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * 100);
        fail_now("timeout, the program did not finish its stores in time");
    end

    initial begin
        void'($urandom(32'h6f11));
        rst_i         = 1'b1;
        stall_i       = 1'b0;
        instruction_i = 32'h0000_0013;
        mem_data_i    = '0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = i_type(i, 0, 3'b000, 0, OPC_OP_IMM);  // addi x0, x0, index.
        end
        for (int i = 0; i < 256; i++) begin
            ram[i] = 32'hc0de_0000 ^ (i * 4);   // Fill tied to the byte address.
        end
        load_program();
        repeat (8) @(posedge clk);
        #10;
        rst_i = 1'b0;
        while (store_addr_q.size() < ROWS) begin
            @(posedge clk);
        end
        repeat (40) @(posedge clk);             // Catch stray stores.
        if (store_addr_q.size() != ROWS) begin
            fail_now($sformatf("%0d stores seen, more than expected", store_addr_q.size()));
        end else begin
            for (int i = 0; i < ROWS; i++) begin
                check_word("mem_address_o", store_addr_q[i], EXP_ADDR[i]);
                check_word("mem_data_o", store_data_q[i], EXP_DATA[i]);
                check_strobe("mem_write_enable_o", store_strb_q[i], 4'b1111);
            end
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/puc_rs5_chk.sv
`timescale 1ns/1ps
`default_nettype none

module puc_rs5_chk (
    input logic              clk,
    input logic              rst_i,
    input logic              stall_i,
    input rv_isa_pkg::word_t instruction_address_o,
    input logic [3:0]        mem_write_enable_o,
    input rv_isa_pkg::word_t mem_address_o
);

    // First cycle out of reset stores nothing.
    no_store_after_reset: assert property (@(posedge clk)
        $fell(rst_i) |-> mem_write_enable_o == 4'b0000)
        else $error("store right after reset");

    // Fetch holds under back-pressure.
    fetch_holds_on_stall: assert property (@(posedge clk) disable iff (rst_i)
        stall_i |=> $stable(instruction_address_o))
        else $error("instruction address moved during stall");

    // Both buses carry word addresses.
    word_aligned: assert property (@(posedge clk) disable iff (rst_i)
        mem_address_o[1:0] == 2'b00 && instruction_address_o[1:0] == 2'b00)
        else $error("unaligned fetch or data address");

endmodule

bind puc_rs5 puc_rs5_chk i_puc_rs5_chk (.*);

`default_nettype wire

//--- source/puc_rs5.sv
`timescale 1ns/1ps
`default_nettype none

module puc_rs5 (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              stall_i,
    input  rv_isa_pkg::word_t instruction_i,
    input  rv_isa_pkg::word_t mem_data_i,
    output rv_isa_pkg::word_t instruction_address_o,
    output logic              mem_operation_enable_o,
    output logic [3:0]        mem_write_enable_o,
    output rv_isa_pkg::word_t mem_address_o,
    output rv_isa_pkg::word_t mem_data_o
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    regbank_if rf ();

    logic       hazard;
    logic       jump;
    word_t      jump_target;
    word_t      pc_decode;
    tag_t       tag_current;
    word_t      rs1_data;           // Bypassed read data.
    word_t      rs2_data;
    dec_pkt_t   dec_pkt;
    logic       dec_valid;
    exe_pkt_t   exe_pkt;
    logic       exe_valid;
    word_t      mem_read_address;
    word_t      mem_write_address;
    logic       mem_read;
    logic       wb_enable_retire;
    logic       wb_enable;
    reg_idx_t   wb_rd;
    word_t      wb_data;
    logic [3:0] store_strobe;

    fetch i_fetch (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .stall_i               (stall_i),
        .hazard_i              (hazard),
        .jump_i                (jump),
        .jump_target_i         (jump_target),
        .instruction_address_o (instruction_address_o),
        .pc_o                  (pc_decode),
        .tag_o                 (tag_current)
    );

    // Retiring write reaches decode in the same cycle.
    assign rs1_data = (rf.rs1 == wb_rd && wb_rd != '0 && wb_enable) ? wb_data : rf.data1;
    assign rs2_data = (rf.rs2 == wb_rd && wb_rd != '0 && wb_enable) ? wb_data : rf.data2;

    decode i_decode (
        .clk           (clk),
        .rst_i         (rst_i),
        .stall_i       (stall_i),
        .instruction_i (instruction_i),
        .pc_i          (pc_decode),
        .tag_i         (tag_current),
        .rf            (rf.reader),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .pkt_o         (dec_pkt),
        .valid_o       (dec_valid),
        .hazard_o      (hazard)
    );

    regbank i_regbank (
        .clk            (clk),
        .rst_i          (rst_i),
        .rf             (rf.bank),
        .write_enable_i (wb_enable),
        .rd_i           (wb_rd),
        .data_i         (wb_data)
    );

    execute i_execute (
        .clk                (clk),
        .rst_i              (rst_i),
        .stall_i            (stall_i),
        .pkt_i              (dec_pkt),
        .valid_i            (dec_valid),
        .pkt_o              (exe_pkt),
        .valid_o            (exe_valid),
        .mem_read_address_o (mem_read_address),
        .mem_read_o         (mem_read)
    );

    retire i_retire (
        .pkt_i                  (exe_pkt),
        .valid_i                (exe_valid),
        .tag_i                  (tag_current),
        .mem_data_i             (mem_data_i),
        .regbank_write_enable_o (wb_enable_retire),
        .regbank_rd_o           (wb_rd),
        .regbank_data_o         (wb_data),
        .jump_o                 (jump),
        .jump_target_o          (jump_target),
        .mem_write_enable_o     (store_strobe),
        .mem_write_address_o    (mem_write_address),
        .mem_data_o             (mem_data_o)
    );

    // Retire repeats while stalled. Commit only once.
    assign wb_enable          = wb_enable_retire && !stall_i;
    assign mem_write_enable_o = stall_i ? 4'b0000 : store_strobe;

    always_comb begin
        if (mem_write_enable_o != '0) begin
            mem_address_o[31:2] = mem_write_address[31:2];  // Store owns the bus.
        end else begin
            mem_address_o[31:2] = mem_read_address[31:2];
        end
        mem_address_o[1:0]     = 2'b00;  // Word accesses only.
        mem_operation_enable_o = (mem_write_enable_o != '0) || mem_read;
    end

endmodule

`default_nettype wire

//--- source/regbank.sv
`timescale 1ns/1ps
`default_nettype none

module regbank (
    input  logic                 clk,
    input  logic                 rst_i,
    regbank_if.bank              rf,
    input  logic                 write_enable_i,
    input  rv_isa_pkg::reg_idx_t rd_i,
    input  rv_isa_pkg::word_t    data_i
);

    import rv_isa_pkg::*;

    word_t regs [1:31];     // x0 has no storage.

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable_i && rd_i != '0) begin
            regs[rd_i] <= data_i;
        end
    end

    assign rf.data1 = (rf.rs1 == '0) ? '0 : regs[rf.rs1];
    assign rf.data2 = (rf.rs2 == '0) ? '0 : regs[rf.rs2];

endmodule

`default_nettype wire

//--- source/retire.sv
`timescale 1ns/1ps
`default_nettype none

module retire (
    input  rv_pipe_pkg::exe_pkt_t pkt_i,
    input  logic                  valid_i,
    input  rv_isa_pkg::tag_t      tag_i,
    input  rv_isa_pkg::word_t     mem_data_i,
    output logic                  regbank_write_enable_o,
    output rv_isa_pkg::reg_idx_t  regbank_rd_o,
    output rv_isa_pkg::word_t     regbank_data_o,
    output logic                  jump_o,
    output rv_isa_pkg::word_t     jump_target_o,
    output logic [3:0]            mem_write_enable_o,
    output rv_isa_pkg::word_t     mem_write_address_o,
    output rv_isa_pkg::word_t     mem_data_o
);

    import rv_isa_pkg::*;

    logic accept;   // Valid and on the current path.

    assign accept = valid_i && pkt_i.tag == tag_i;

    // Writeback. x0 never written.
    assign regbank_write_enable_o = accept && pkt_i.write_enable && pkt_i.rd != '0;
    assign regbank_rd_o           = pkt_i.rd;
    assign regbank_data_o         = (pkt_i.op == OP_LW) ? mem_data_i : pkt_i.result;

    assign jump_o        = accept && pkt_i.jump;
    assign jump_target_o = pkt_i.target;

    // Word stores only.
    assign mem_write_enable_o  = {4{accept && pkt_i.mem_write}};
    assign mem_write_address_o = pkt_i.result;
    assign mem_data_o          = pkt_i.store_data;

endmodule

`default_nettype wire

//--- source/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  rv_pipe_pkg::dec_pkt_t pkt_i,
    input  logic                  valid_i,
    output rv_pipe_pkg::exe_pkt_t pkt_o,
    output logic                  valid_o,
    output rv_isa_pkg::word_t     mem_read_address_o,
    output logic                  mem_read_o
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t    sum;          // ADD, addresses and JALR base.
    word_t    link;
    word_t    alu_result;
    logic     equal;
    logic     less_s;
    logic     less_u;
    logic     taken;
    exe_pkt_t next;

    assign sum    = pkt_i.first + pkt_i.second;
    assign link   = pkt_i.pc + 32'd4;
    assign equal  = pkt_i.first == pkt_i.second;
    assign less_s = $signed(pkt_i.first) < $signed(pkt_i.second);
    assign less_u = pkt_i.first < pkt_i.second;

    always_comb begin
        case (pkt_i.op)
            OP_SUB:  alu_result = pkt_i.first - pkt_i.second;
            OP_AND:  alu_result = pkt_i.first & pkt_i.second;
            OP_OR:   alu_result = pkt_i.first | pkt_i.second;
            OP_XOR:  alu_result = pkt_i.first ^ pkt_i.second;
            OP_SLT:  alu_result = {31'b0, less_s};
            OP_SLTU: alu_result = {31'b0, less_u};
            OP_SLL:  alu_result = pkt_i.first << pkt_i.second[4:0];
            OP_SRL:  alu_result = pkt_i.first >> pkt_i.second[4:0];
            OP_SRA:  alu_result = $signed(pkt_i.first) >>> pkt_i.second[4:0];
            OP_LUI:  alu_result = pkt_i.second;
            OP_JAL,
            OP_JALR: alu_result = link;         // Return address.
            default: alu_result = sum;          // ADD, AUIPC, LW and SW.
        endcase
    end

    always_comb begin
        case (pkt_i.op)
            OP_BEQ:  taken = equal;
            OP_BNE:  taken = !equal;
            OP_BLT:  taken = less_s;
            OP_BGE:  taken = !less_s;
            OP_JAL,
            OP_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        next.op     = pkt_i.op;
        next.rd     = pkt_i.rd;
        next.result = alu_result;
        // JALR drops bit 0. Branches and JAL are pc relative.
        next.target = (pkt_i.op == OP_JALR) ? {sum[31:1], 1'b0} : pkt_i.pc + pkt_i.third;
        next.write_enable = pkt_i.rd != '0;     // Decode clears rd otherwise.
        next.jump         = taken;
        next.mem_write    = pkt_i.op == OP_SW;
        next.store_data   = pkt_i.third;
        next.tag          = pkt_i.tag;
    end

    // Load address goes out now, data is back when the load retires.
    assign mem_read_address_o = sum;
    assign mem_read_o         = valid_i && pkt_i.op == OP_LW;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
            pkt_o   <= next;
        end
    end

endmodule

`default_nettype wire

//--- source/decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module decode (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  stall_i,
    input  rv_isa_pkg::word_t     instruction_i,
    input  rv_isa_pkg::word_t     pc_i,
    input  rv_isa_pkg::tag_t      tag_i,
    regbank_if.reader             rf,
    input  rv_isa_pkg::word_t     rs1_data_i,
    input  rv_isa_pkg::word_t     rs2_data_i,
    output rv_pipe_pkg::dec_pkt_t pkt_o,
    output logic                  valid_o,
    output logic                  hazard_o
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t      instruction;    // Word being decoded this cycle.
    word_t      inst_q;         // Copy kept across a hold.
    logic       held_q;         // Last cycle held, so memory moved on.
    tag_t       tag_q;          // Epoch when the word was fetched.
    opcode_e    opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    dec_pkt_t   next;

    // Register and immediate ALU ops share funct3.
    function automatic op_e alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? OP_SUB : OP_ADD;
            3'b001:  return OP_SLL;
            3'b010:  return OP_SLT;
            3'b011:  return OP_SLTU;
            3'b100:  return OP_XOR;
            3'b101:  return alt ? OP_SRA : OP_SRL;
            3'b110:  return OP_OR;
            default: return OP_AND;
        endcase
    endfunction

    assign instruction = held_q ? inst_q : instruction_i;
    assign opcode      = opcode_e'(instruction[6:0]);
    assign funct3      = instruction[14:12];
    assign rf.rs1      = instruction[19:15];
    assign rf.rs2      = instruction[24:20];

    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        next        = '0;
        next.pc     = pc_i;
        next.tag    = tag_q;
        next.rd     = instruction[11:7];
        next.first  = rs1_data_i;
        next.second = rs2_data_i;
        next.third  = rs2_data_i;   // Store data by default.
        next.op     = OP_NOP;
        case (opcode)
            OPC_OP: next.op = alu_op(funct3, instruction[30]);
            OPC_OP_IMM: begin
                next.op     = alu_op(funct3, funct3 == 3'b101 && instruction[30]);
                next.second = imm_i;    // Shamt sits in the low bits.
            end
            OPC_LUI: begin
                next.op     = OP_LUI;
                next.second = imm_u;
            end
            OPC_AUIPC: begin
                next.op     = OP_ADD;   // pc + upper immediate.
                next.first  = pc_i;
                next.second = imm_u;
            end
            OPC_LOAD: begin
                next.op     = (funct3 == 3'b010) ? OP_LW : OP_NOP;
                next.second = imm_i;
            end
            OPC_STORE: begin
                next.op     = (funct3 == 3'b010) ? OP_SW : OP_NOP;
                next.second = imm_s;
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  next.op = OP_BEQ;
                    3'b001:  next.op = OP_BNE;
                    3'b100:  next.op = OP_BLT;
                    3'b101:  next.op = OP_BGE;
                    default: next.op = OP_NOP;
                endcase
                next.third = imm_b;
            end
            OPC_JAL: begin
                next.op    = OP_JAL;
                next.third = imm_j;
            end
            OPC_JALR: begin
                next.op     = (funct3 == 3'b000) ? OP_JALR : OP_NOP;
                next.second = imm_i;
            end
            default: next.op = OP_NOP;
        endcase
        if (next.op inside {OP_SW, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_NOP}) begin
            next.rd = '0;   // No writeback, so no hazard either.
        end
    end

    // Result of the instruction in execute is not readable yet.
    assign hazard_o = valid_o && pkt_o.rd != '0 &&
                      (rf.rs1 == pkt_o.rd || rf.rs2 == pkt_o.rd);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            held_q  <= 1'b1;        // First word after reset is stale.
            inst_q  <= `RV_NOP;
            tag_q   <= '0;
        end else begin
            held_q <= stall_i || hazard_o;
            inst_q <= instruction;
            if (!stall_i) begin
                valid_o <= !hazard_o;   // Bubble while holding.
                pkt_o   <= next;
                if (!hazard_o) begin
                    tag_q <= tag_i;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module fetch (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              stall_i,
    input  logic              hazard_i,
    input  logic              jump_i,
    input  rv_isa_pkg::word_t jump_target_i,
    output rv_isa_pkg::word_t instruction_address_o,
    output rv_isa_pkg::word_t pc_o,
    output rv_isa_pkg::tag_t  tag_o
);

    import rv_isa_pkg::*;

    word_t pc;      // Address being fetched now.
    tag_t  tag;     // Current epoch, also the one retire accepts.

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc   <= `RV_RESET_PC;
            pc_o <= `RV_RESET_PC;
            tag  <= '0;
        end else if (!stall_i) begin
            if (jump_i) begin
                pc  <= jump_target_i;   // Redirect wins over a hazard hold.
                tag <= tag + 1'b1;      // Older instructions are now stale.
            end else if (!hazard_i) begin
                pc <= pc + 32'd4;
            end
            if (!hazard_i) begin
                pc_o <= pc;             // Travels with the returning word.
            end
        end
    end

    assign instruction_address_o = pc;
    assign tag_o                 = tag;

endmodule

`default_nettype wire

//--- source/regbank_if.sv
`timescale 1ns/1ps
`default_nettype none

// Two combinational read ports of the register bank.
interface regbank_if;

    import rv_isa_pkg::*;

    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    data1;
    word_t    data2;

    modport reader (output rs1, output rs2, input data1, input data2);
    modport bank (input rs1, input rs2, output data1, output data2);

endinterface

`default_nettype wire

//--- source/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // Decode to execute.
    typedef struct packed {
        word_t    pc;
        op_e      op;
        reg_idx_t rd;       // Zero when nothing is written back.
        word_t    first;    // rs1 or pc.
        word_t    second;   // rs2 or immediate.
        word_t    third;    // Store data or branch/JAL offset.
        tag_t     tag;
    } dec_pkt_t;

    // Execute to retire.
    typedef struct packed {
        op_e      op;
        reg_idx_t rd;
        word_t    result;       // ALU value, link or memory address.
        word_t    target;       // Jump destination.
        logic     write_enable;
        logic     jump;         // Taken branch or jump.
        logic     mem_write;
        word_t    store_data;
        tag_t     tag;
    } exe_pkt_t;

endpackage

`default_nettype wire

//--- source/rv_isa_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_isa_pkg;

    typedef logic [31:0] word_t;                // Data or address word.
    typedef logic [4:0] reg_idx_t;              // Register index.
    typedef logic [`RV_TAG_W-1:0] tag_t;        // Epoch of an instruction.

    // Internal operations after decode.
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_JAL,
        OP_JALR,
        OP_NOP
    } op_e;

    // RV32I major opcodes that the core knows.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

endpackage

`default_nettype wire

//--- source/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// First fetch address out of reset.
`define RV_RESET_PC 32'h0000_0000

// Control-flow epoch width. Wraps harmlessly.
`define RV_TAG_W 3

// ADDI x0, x0, 0.
`define RV_NOP 32'h0000_0013

`endif
